// File: mips_core.f
src/mips_pkg.sv
src/mips_ctrl_if.sv
src/mips_sequencer.sv
src/mips_decode.sv
src/mips_execute.sv
src/mips_result.sv
src/mips_core.sv
test/mips_checker.sv
test/tb_mips_core.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module tb_mips_core -f mips_core.f &&
./obj_dir/Vtb_mips_core | tee /dev/stderr | grep -qx "STATUS: PASS" &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: src/mips_core.sv
// Multicycle MIPS32 subset core with one Wishbone classic master port and RESET_PC assumed word-aligned.
`timescale 1ns/1ps

module mips_core #(
    parameter mips_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        arst_n,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic        wb_we,
    output logic [31:0] wb_adr,
    output logic [31:0] wb_dat_w,
    output logic [3:0]  wb_sel,
    input  logic [31:0] wb_dat_r,
    input  logic        wb_ack
);
    import mips_pkg::*;

    word_t instr;
    word_t pc;
    word_t next_pc;
    word_t alu_result;
    word_t alu_reg;
    word_t mem_data;
    word_t rs_data;
    word_t rt_data;
    logic  wb_en;

    mips_ctrl_if ctrl_bus ();

    mips_sequencer #(
        .RESET_PC (RESET_PC)
    ) u_sequencer (
        .clk        (clk),
        .arst_n     (arst_n),
        .next_pc    (next_pc),
        .alu_result (alu_result),
        .store_data (rt_data),
        .instr      (instr),
        .pc         (pc),
        .alu_reg    (alu_reg),
        .mem_data   (mem_data),
        .wb_en      (wb_en),
        .ctrl       (ctrl_bus.seq),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_sel     (wb_sel),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack)
    );

    mips_decode u_decode (.instr(instr), .ctrl(ctrl_bus.dec));

    mips_execute u_execute (
        .instr      (instr),
        .pc         (pc),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .alu_result (alu_result),
        .next_pc    (next_pc),
        .ctrl       (ctrl_bus.exe)
    );

    mips_result u_result (
        .clk      (clk),
        .arst_n   (arst_n),
        .instr    (instr),
        .pc       (pc),
        .alu_reg  (alu_reg),
        .mem_data (mem_data),
        .wb_en    (wb_en),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .ctrl     (ctrl_bus.res)
    );

endmodule

// File: src/mips_ctrl_if.sv
// Control fields are levels that follow the instruction register and hold for the whole instruction.
`timescale 1ns/1ps

interface mips_ctrl_if;
    import mips_pkg::*;

    alu_op_e alu_op;
    logic    alu_src_imm;  // second operand from the immediate
    logic    reg_dst_rd;   // write index from rd instead of rt
    wb_sel_e wb_sel;
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    branch;
    logic    branch_ne;    // bne flips the equality test
    logic    jump;

    modport dec (
        output alu_op, alu_src_imm, reg_dst_rd, wb_sel, reg_write,
        output mem_read, mem_write, branch, branch_ne, jump
    );
    modport exe (input alu_op, alu_src_imm, branch, branch_ne, jump);
    modport res (input reg_dst_rd, wb_sel, reg_write);
    modport seq (input mem_read, mem_write);

endinterface

// File: src/mips_decode.sv
// Decodes the kept subset only and turns unknown opcodes or function codes into no-ops without writes.
`timescale 1ns/1ps

module mips_decode (
    input  mips_pkg::word_t instr,
    mips_ctrl_if.dec        ctrl
);
    import mips_pkg::*;

    opcode_e opcode;
    funct_e  funct;

    assign opcode = opcode_e'(instr[31:26]);
    assign funct  = funct_e'(instr[5:0]);

    always_comb begin
        ctrl.alu_op      = ALU_ADD;
        ctrl.alu_src_imm = 1'b0;
        ctrl.reg_dst_rd  = 1'b0;
        ctrl.wb_sel      = WB_ALU;
        ctrl.reg_write   = 1'b0;
        ctrl.mem_read    = 1'b0;
        ctrl.mem_write   = 1'b0;
        ctrl.branch      = 1'b0;
        ctrl.branch_ne   = 1'b0;
        ctrl.jump        = 1'b0;

        case (opcode)
            OP_RTYPE: begin
                ctrl.reg_dst_rd = 1'b1;
                ctrl.reg_write  = 1'b1;
                case (funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_XOR:  ctrl.alu_op = ALU_XOR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_SLTU: ctrl.alu_op = ALU_SLTU;
                    default: ctrl.reg_write = 1'b0; // shifts, mult/div and jr fall here
                endcase
            end
            OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
                case (opcode)
                    OP_ANDI: ctrl.alu_op = ALU_AND;
                    OP_ORI:  ctrl.alu_op = ALU_OR;
                    OP_XORI: ctrl.alu_op = ALU_XOR;
                    OP_LUI:  ctrl.alu_op = ALU_LUI;
                    default: ctrl.alu_op = ALU_ADD;
                endcase
            end
            OP_LW: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.wb_sel      = WB_MEM;
                ctrl.reg_write   = 1'b1;
            end
            OP_SW: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                ctrl.alu_op    = ALU_SUB;
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = (opcode == OP_BNE);
            end
            OP_J: begin
                ctrl.jump = 1'b1;
            end
            OP_JAL: begin
                ctrl.jump      = 1'b1;
                ctrl.wb_sel    = WB_LINK; // pc+4 into r31
                ctrl.reg_write = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

// File: src/mips_execute.sv
// Purely combinational ALU and next-PC logic with no delay slot and no overflow trap.
`timescale 1ns/1ps

module mips_execute (
    input  mips_pkg::word_t instr,
    input  mips_pkg::word_t pc,
    input  mips_pkg::word_t rs_data,
    input  mips_pkg::word_t rt_data,
    output mips_pkg::word_t alu_result,
    output mips_pkg::word_t next_pc,
    mips_ctrl_if.exe        ctrl
);
    import mips_pkg::*;

    word_t imm_ext;
    word_t op_b;
    word_t pc_plus4;
    word_t branch_target;
    word_t jump_target;
    logic  zero_ext;
    logic  taken;

    // logical immediates are zero-extended
    assign zero_ext = (ctrl.alu_op == ALU_AND) || (ctrl.alu_op == ALU_OR)
                      || (ctrl.alu_op == ALU_XOR);
    assign imm_ext  = zero_ext ? {16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
    assign op_b     = ctrl.alu_src_imm ? imm_ext : rt_data;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:  alu_result = rs_data + op_b;
            ALU_SUB:  alu_result = rs_data - op_b;
            ALU_AND:  alu_result = rs_data & op_b;
            ALU_OR:   alu_result = rs_data | op_b;
            ALU_XOR:  alu_result = rs_data ^ op_b;
            ALU_SLT:  alu_result = {{(XLEN-1){1'b0}}, $signed(rs_data) < $signed(op_b)};
            ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, rs_data < op_b};
            ALU_LUI:  alu_result = {op_b[15:0], 16'b0};
            default:  alu_result = rs_data + op_b;
        endcase
    end

    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + {{14{instr[15]}}, instr[15:0], 2'b00};
    assign jump_target   = {pc_plus4[31:28], instr[25:0], 2'b00}; // 256 MB region of pc+4

    assign taken = ctrl.branch && ((rs_data == rt_data) != ctrl.branch_ne);

    always_comb begin
        if (ctrl.jump)
            next_pc = jump_target;
        else if (taken)
            next_pc = branch_target;
        else
            next_pc = pc_plus4;
    end

endmodule

// File: src/mips_pkg.sv
// Encodings cover only the kept MIPS32 subset and any other opcode or function code decodes as a no-op.
package mips_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] reg_idx_t;

    localparam reg_idx_t LINK_REG = 5'd31; // return address target of jal

    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,
        OP_J     = 6'b000010,
        OP_JAL   = 6'b000011,
        OP_BEQ   = 6'b000100,
        OP_BNE   = 6'b000101,
        OP_ADDIU = 6'b001001,
        OP_ANDI  = 6'b001100,
        OP_ORI   = 6'b001101,
        OP_XORI  = 6'b001110,
        OP_LUI   = 6'b001111,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU, ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU, WB_MEM, WB_LINK
    } wb_sel_e;

endpackage

// File: src/mips_result.sv
// The 32-entry register file has no reset, so registers other than r0 hold unknown values until written.
`timescale 1ns/1ps

module mips_result (
    input  logic            clk,
    input  logic            arst_n,
    input  mips_pkg::word_t instr,
    input  mips_pkg::word_t pc,
    input  mips_pkg::word_t alu_reg,
    input  mips_pkg::word_t mem_data,
    input  logic            wb_en,
    output mips_pkg::word_t rs_data,
    output mips_pkg::word_t rt_data,
    mips_ctrl_if.res        ctrl
);
    import mips_pkg::*;

    word_t    regs [2**REG_AW];
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    reg_idx_t dst_idx;
    word_t    wr_data;
    logic     rf_we;

    assign rs_idx = instr[25:21];
    assign rt_idx = instr[20:16];

    assign rs_data = (rs_idx == '0) ? '0 : regs[rs_idx];
    assign rt_data = (rt_idx == '0) ? '0 : regs[rt_idx];

    always_comb begin
        if (ctrl.wb_sel == WB_LINK)
            dst_idx = LINK_REG;
        else if (ctrl.reg_dst_rd)
            dst_idx = instr[15:11];
        else
            dst_idx = rt_idx;
    end

    always_comb begin
        case (ctrl.wb_sel)
            WB_MEM:  wr_data = mem_data;
            WB_LINK: wr_data = pc + 32'd4; // pc still holds the jal address here
            default: wr_data = alu_reg;
        endcase
    end

    assign rf_we = wb_en && ctrl.reg_write;

    always_ff @(posedge clk) begin
        if (rf_we && dst_idx != '0)
            regs[dst_idx] <= wr_data;
    end

    // one write per instruction, taken from a single-cycle writeback pulse
    assert property (@(posedge clk) disable iff (!arst_n) rf_we |=> !wb_en && !rf_we);

endmodule

// File: src/mips_sequencer.sv
// Single Wishbone classic master shared by fetch and data with no retry or error support and a word-aligned RESET_PC.
`timescale 1ns/1ps

module mips_sequencer #(
    parameter mips_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic            clk,
    input  logic            arst_n,
    input  mips_pkg::word_t next_pc,
    input  mips_pkg::word_t alu_result,
    input  mips_pkg::word_t store_data,
    output mips_pkg::word_t instr,
    output mips_pkg::word_t pc,
    output mips_pkg::word_t alu_reg,
    output mips_pkg::word_t mem_data,
    output logic            wb_en,
    mips_ctrl_if.seq        ctrl,
    output logic            wb_cyc,
    output logic            wb_stb,
    output logic            wb_we,
    output mips_pkg::word_t wb_adr,
    output mips_pkg::word_t wb_dat_w,
    output logic [3:0]      wb_sel,
    input  mips_pkg::word_t wb_dat_r,
    input  logic            wb_ack
);

    typedef enum logic [2:0] {
        S_FETCH, S_DECODE, S_EXEC, S_MEM, S_WRITEBACK
    } state_e;

    state_e state;
    logic   pc_en;
    logic   mem_op;
    logic   bus_done;

    assign mem_op   = ctrl.mem_read || ctrl.mem_write;
    assign bus_done = wb_cyc && wb_ack;
    assign wb_en    = (state == S_WRITEBACK);
    assign pc_en    = (state == S_WRITEBACK);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_FETCH;
        end else begin
            case (state)
                S_FETCH: begin
                    if (bus_done)
                        state <= S_DECODE;
                end
                S_DECODE:    state <= S_EXEC;
                S_EXEC:      state <= mem_op ? S_MEM : S_WRITEBACK;
                S_MEM: begin
                    if (bus_done)
                        state <= S_WRITEBACK;
                end
                default:     state <= S_FETCH; // writeback closes the instruction
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc    <= RESET_PC;
            instr <= '0;
        end else begin
            if (pc_en)
                pc <= next_pc;
            if (state == S_FETCH && bus_done)
                instr <= wb_dat_r;
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_EXEC)
            alu_reg <= alu_result; // data address or writeback value
        if (state == S_MEM && bus_done && ctrl.mem_read)
            mem_data <= wb_dat_r;
    end

    // cyc rises on the edge that enters FETCH or MEM, so no idle cycle is spent
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_cyc <= 1'b0;
        end else if (wb_cyc) begin
            if (wb_ack)
                wb_cyc <= 1'b0;
        end else if (state == S_FETCH || state == S_WRITEBACK || (state == S_EXEC && mem_op)) begin
            wb_cyc <= 1'b1; // FETCH case only hits right after reset
        end
    end

    assign wb_stb   = wb_cyc;
    assign wb_we    = (state == S_MEM) && ctrl.mem_write;
    assign wb_adr   = (state == S_MEM) ? alu_reg : pc;
    assign wb_dat_w = store_data; // rt is not written while a bus cycle runs
    assign wb_sel   = 4'b1111;

    // a pending strobe keeps the whole request steady until ack
    assert property (@(posedge clk) disable iff (!arst_n)
        wb_stb && !wb_ack |=> wb_stb && wb_cyc && $stable(wb_adr) && $stable(wb_we)
                              && $stable(wb_dat_w));

    assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00);

endmodule

// File: test/mips_checker.sv
// Bus-driven reference model that assumes every register is written before it is read and ack only comes inside wb_cyc.
`timescale 1ns/1ps

module mips_checker #(
    parameter mips_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            wb_cyc,
    input  logic            wb_stb,
    input  logic            wb_we,
    input  mips_pkg::word_t wb_adr,
    input  mips_pkg::word_t wb_dat_w,
    input  logic [3:0]      wb_sel,
    input  mips_pkg::word_t wb_dat_r,
    input  logic            wb_ack,
    output int              errors,
    output int              checks
);
    import mips_pkg::*;

    word_t    regs [32];
    word_t    model_pc;
    logic     data_pending;  // fetched lw or sw still owes its data cycle
    logic     pend_we;
    word_t    pend_adr;
    word_t    pend_dat;
    reg_idx_t pend_rt;
    logic     prev_cyc;
    logic     prev_stb;
    logic     prev_ack;
    logic     prev_we;
    word_t    prev_adr;
    word_t    prev_dat;
    int       err_cnt = 0;
    int       chk_cnt = 0;

    assign errors = err_cnt;
    assign checks = chk_cnt;

    task automatic compare(input string name, input word_t got, input word_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // executes one fetched instruction on the model state
    task automatic run_instr(input word_t ins);
        word_t    a;
        word_t    b;
        word_t    sext;
        word_t    zext;
        word_t    npc;
        word_t    val;
        reg_idx_t dst;
        logic     wr;
        a    = regs[ins[25:21]];
        b    = regs[ins[20:16]];
        sext = {{16{ins[15]}}, ins[15:0]};
        zext = {16'h0000, ins[15:0]};
        npc  = model_pc + 32'd4;
        dst  = ins[20:16];
        val  = '0;
        wr   = 1'b1;
        case (ins[31:26])
            OP_RTYPE: begin
                dst = ins[15:11];
                case (ins[5:0])
                    FN_ADDU: val = a + b;
                    FN_SUBU: val = a - b;
                    FN_AND:  val = a & b;
                    FN_OR:   val = a | b;
                    FN_XOR:  val = a ^ b;
                    FN_SLT:  val = {31'd0, $signed(a) < $signed(b)};
                    FN_SLTU: val = {31'd0, a < b};
                    default: wr = 1'b0;
                endcase
            end
            OP_ADDIU: val = a + sext;
            OP_ANDI:  val = a & zext;
            OP_ORI:   val = a | zext;
            OP_XORI:  val = a ^ zext;
            OP_LUI:   val = {ins[15:0], 16'h0000};
            OP_BEQ, OP_BNE: begin
                wr = 1'b0;
                if ((a == b) == (ins[31:26] == OP_BEQ))
                    npc = npc + {sext[29:0], 2'b00};
            end
            OP_J, OP_JAL: begin
                wr  = (ins[31:26] == OP_JAL);
                dst = 5'd31;  // link register
                val = npc;
                npc = {npc[31:28], ins[25:0], 2'b00};
            end
            OP_LW, OP_SW: begin
                wr           = 1'b0;
                data_pending = 1'b1;
                pend_we      = (ins[31:26] == OP_SW);
                pend_adr     = a + sext;
                pend_dat     = b;
                pend_rt      = ins[20:16];
            end
            default: wr = 1'b0;
        endcase
        if (wr && dst != '0)
            regs[dst] = val;
        model_pc = npc;
    endtask

    // one acknowledged bus cycle, either the owed data access or a fetch
    task automatic bus_ack();
        compare("wb_we", {31'd0, wb_we}, {31'd0, data_pending && pend_we});
        if (data_pending) begin
            compare("wb_adr (data)", wb_adr, pend_adr);
            if (pend_we)
                compare("wb_dat_w", wb_dat_w, pend_dat);
            else if (pend_rt != '0)
                regs[pend_rt] = wb_dat_r;
            data_pending = 1'b0;
        end else begin
            compare("wb_adr (fetch)", wb_adr, model_pc);
            run_instr(wb_dat_r);
        end
    endtask

    always @(posedge clk) begin
        if (!arst_n) begin
            compare("wb_cyc (reset)", {31'd0, wb_cyc}, '0);
            for (int i = 0; i < 32; i++)
                regs[i] = '0;
            model_pc     = RESET_PC;
            data_pending = 1'b0;
            prev_cyc     = 1'b0;
            prev_stb     = 1'b0;
            prev_ack     = 1'b0;
        end else begin
            compare("wb_stb", {31'd0, wb_stb}, {31'd0, wb_cyc});
            if (wb_cyc)
                compare("wb_sel", {28'd0, wb_sel}, 32'h0000_000f);
            if (prev_stb && !prev_ack) begin  // request must hold until ack
                compare("wb_stb (held)", {31'd0, wb_stb}, 32'd1);
                compare("wb_adr (held)", wb_adr, prev_adr);
                compare("wb_we (held)", {31'd0, wb_we}, {31'd0, prev_we});
                if (prev_we)
                    compare("wb_dat_w (held)", wb_dat_w, prev_dat);
            end
            if (prev_cyc && prev_ack)
                compare("wb_cyc (after ack)", {31'd0, wb_cyc}, '0);
            if (wb_cyc && wb_ack)
                bus_ack();
            prev_cyc = wb_cyc;
            prev_stb = wb_stb;
            prev_ack = wb_ack;
            prev_we  = wb_we;
            prev_adr = wb_adr;
            prev_dat = wb_dat_w;
        end
    end

endmodule

// File: test/tb_mips_core.sv
// Random program at RESET_PC 0 with a 2048-word memory, data at 0x1000 and the register dump at 0x1800.
`timescale 1ns/1ps

module tb_mips_core;
    import mips_pkg::*;

    localparam word_t RESET_PC  = 32'h0000_0000;
    localparam int    PROG_BASE = int'(RESET_PC >> 2);
    localparam int    N_RANDOM  = 200;
    localparam int    END_IDX   = PROG_BASE + 31 + N_RANDOM + 32;  // word of the self-jump
    localparam word_t END_ADR   = 32'(END_IDX * 4);
    localparam int    MEM_WORDS = 2048;
    localparam int    TIMEOUT   = (31 + N_RANDOM + 32 + 2) * 12 + 64;

    logic        clk;
    logic        arst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    word_t       wb_adr;
    word_t       wb_dat_w;
    logic [3:0]  wb_sel;
    word_t       wb_dat_r;
    logic        wb_ack;
    word_t       mem [MEM_WORDS];
    logic [31:0] rnd;
    int          wait_left;
    int          end_hits;
    int          cycles;
    int          errors;
    int          checks;

    mips_core #(.RESET_PC(RESET_PC)) DUT (.*);

    mips_checker #(.RESET_PC(RESET_PC)) u_checker (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t r_type(input funct_e fn, input int rs, input int rt, input int rd);
        return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic word_t i_type(input opcode_e op, input int rs, input int rt,
                                     input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic word_t j_type(input opcode_e op, input word_t target);
        return {op, target[27:2]};
    endfunction

    // prologue sets every register, then random body, register dump and self-jump
    task automatic build_program();
        int          at;
        logic [31:0] r1;
        logic [31:0] r2;
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = (32'(i) * 32'h9e37_79b9) ^ 32'h5bd1_e995;
        at = PROG_BASE;
        for (int r = 1; r < 32; r++) begin
            rnd = xorshift(rnd);
            mem[at] = i_type(OP_ADDIU, 0, r, rnd[15:0]);
            at++;
        end
        for (int n = 0; n < N_RANDOM; n++) begin
            rnd = xorshift(rnd);
            r1  = rnd;
            rnd = xorshift(rnd);
            r2  = rnd;
            case (r1[3:0])
                4'd0, 4'd1, 4'd2, 4'd3, 4'd4: begin
                    case (r1[10:8])
                        3'd0:    mem[at] = r_type(FN_ADDU, r1[15:11], r1[20:16], r1[25:21]);
                        3'd1:    mem[at] = r_type(FN_SUBU, r1[15:11], r1[20:16], r1[25:21]);
                        3'd2:    mem[at] = r_type(FN_AND, r1[15:11], r1[20:16], r1[25:21]);
                        3'd3:    mem[at] = r_type(FN_OR, r1[15:11], r1[20:16], r1[25:21]);
                        3'd4:    mem[at] = r_type(FN_XOR, r1[15:11], r1[20:16], r1[25:21]);
                        3'd5:    mem[at] = r_type(FN_SLT, r1[15:11], r1[20:16], r1[25:21]);
                        default: mem[at] = r_type(FN_SLTU, r1[15:11], r1[20:16], r1[25:21]);
                    endcase
                end
                4'd5, 4'd6, 4'd7, 4'd8, 4'd9: begin
                    case (r1[10:8])
                        3'd1, 3'd6: mem[at] = i_type(OP_ANDI, r1[15:11], r1[20:16], r2[15:0]);
                        3'd2, 3'd7: mem[at] = i_type(OP_ORI, r1[15:11], r1[20:16], r2[15:0]);
                        3'd3:       mem[at] = i_type(OP_XORI, r1[15:11], r1[20:16], r2[15:0]);
                        3'd4:       mem[at] = i_type(OP_LUI, 0, r1[20:16], r2[15:0]);
                        default:    mem[at] = i_type(OP_ADDIU, r1[15:11], r1[20:16], r2[15:0]);
                    endcase
                end
                4'd10: mem[at] = i_type(OP_LW, 0, r1[20:16], 16'h1000 + {6'd0, r2[7:0], 2'b00});
                4'd11: mem[at] = i_type(OP_SW, 0, r1[20:16], 16'h1000 + {6'd0, r2[7:0], 2'b00});
                4'd12: mem[at] = i_type(OP_BEQ, r1[15:11], r1[20:16], {14'd0, r2[1:0]});
                4'd13: mem[at] = i_type(OP_BNE, r1[15:11], r1[20:16], {14'd0, r2[1:0]});
                4'd14: mem[at] = j_type(OP_J, 32'((at + 1 + int'(r2[1:0])) * 4));
                default: mem[at] = j_type(OP_JAL, 32'((at + 1 + int'(r2[1:0])) * 4));
            endcase
            at++;
        end
        for (int r = 0; r < 32; r++) begin
            mem[at] = i_type(OP_SW, 0, r, 16'h1800 + 16'(r * 4));
            at++;
        end
        mem[END_IDX] = j_type(OP_J, END_ADR);
    endtask

    // memory model answers each strobe after 0 to 3 wait cycles
    initial begin
        wb_ack    = 1'b0;
        wb_dat_r  = '0;
        end_hits  = 0;
        rnd       = 32'h4af0_93e7;
        build_program();
        wait_left = int'(rnd[1:0]);
        forever begin
            @(negedge clk);
            if (wb_ack) begin
                wb_ack = 1'b0;
            end else if (arst_n && wb_cyc && wb_stb) begin
                if (wait_left == 0) begin
                    if (wb_we) begin
                        mem[wb_adr[12:2]] = wb_dat_w;
                    end else begin
                        wb_dat_r = mem[wb_adr[12:2]];
                        if (wb_adr == END_ADR)
                            end_hits++;
                    end
                    wb_ack    = 1'b1;
                    rnd       = xorshift(rnd);
                    wait_left = int'(rnd[1:0]);
                end else begin
                    wait_left--;
                end
            end
        end
    end

    initial begin
        arst_n = 1'b0;
        cycles = 0;
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        while (end_hits < 2 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        repeat (2) @(negedge clk);  // let the checker take the last ack
        if (end_hits < 2)
            $display("timeout: self-jump not fetched twice within %0d cycles", TIMEOUT);
        $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
        if (errors == 0 && end_hits >= 2)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule
